// ==== include/floo_dirs.svh ====
`ifndef FLOO_DIRS_SVH
`define FLOO_DIRS_SVH

// Router port indices, shared by the package and the testbench
`define FLOO_DIR_N 0
`define FLOO_DIR_E 1
`define FLOO_DIR_S 2
`define FLOO_DIR_W 3
`define FLOO_DIR_L 4
`define FLOO_NUM_DIRS 5

`endif

// ==== logic/floo_pkg.sv ====
`include "floo_dirs.svh"

package floo_pkg;

  // Router geometry
  localparam int unsigned NumPorts = `FLOO_NUM_DIRS;
  localparam int unsigned NumVC = 2;
  localparam int unsigned VCDepth = 2;
  localparam int unsigned VCIdWidth = 1;
  localparam int unsigned CoordWidth = 2;
  localparam int unsigned PortIdWidth = 3;

  // Derived widths
  localparam int unsigned CreditWidth = $clog2(VCDepth + 1);
  localparam int unsigned VCPtrWidth = (VCDepth > 1) ? $clog2(VCDepth) : 1;
  localparam int unsigned NumReq = NumPorts * NumVC;
  localparam int unsigned ReqIdWidth = $clog2(NumReq);

  typedef enum logic [PortIdWidth-1:0] {
    PortN = `FLOO_DIR_N,
    PortE = `FLOO_DIR_E,
    PortS = `FLOO_DIR_S,
    PortW = `FLOO_DIR_W,
    PortL = `FLOO_DIR_L
  } port_e;

  typedef struct packed {
    logic [CoordWidth-1:0] x;
    logic [CoordWidth-1:0] y;
  } coord_t;

  typedef struct packed {
    coord_t dst;
    coord_t src;
    logic [7:0] seq;
  } hdr_t;

  typedef logic [VCIdWidth-1:0] vc_id_t;

  typedef struct packed {
    hdr_t hdr;
    logic [31:0] payload;
  } req_flit_t;

  typedef struct packed {
    hdr_t hdr;
    logic [31:0] payload;
  } rsp_flit_t;

  typedef struct packed {
    hdr_t hdr;
    logic [63:0] payload;
  } wide_flit_t;

  // X first, then Y; east is +x and north is +y
  function automatic port_e xy_route(coord_t dst, coord_t here);
    port_e dir;
    if (dst.x > here.x) dir = PortE;
    else if (dst.x < here.x) dir = PortW;
    else if (dst.y > here.y) dir = PortN;
    else if (dst.y < here.y) dir = PortS;
    else dir = PortL;
    return dir;
  endfunction

endpackage

// ==== logic/vc_alloc_if.sv ====
`timescale 1ns/100ps

// Request and grant signals between one input port and the switch allocator
interface vc_alloc_if;
  import floo_pkg::*;

  // One request per VC, valid while that VC buffer holds a flit
  logic [NumVC-1:0] req_v;
  // XY output port of each VC head
  port_e out_port [NumVC];

  // At most one VC of the port is granted per cycle
  logic grant_v;
  vc_id_t grant_vc;

  modport port_side (
    output req_v,
    output out_port,
    input  grant_v,
    input  grant_vc
  );

  modport alloc_side (
    input  req_v,
    input  out_port,
    output grant_v,
    output grant_vc
  );

endinterface

// ==== logic/vc_input_port.sv ====
`timescale 1ns/100ps

module vc_input_port #(
  parameter type flit_t = floo_pkg::req_flit_t
) (
  input  logic clk_i,
  input  logic reset_i,
  input  floo_pkg::coord_t id_i,

  input  logic valid_i,
  input  flit_t flit_i,
  input  floo_pkg::vc_id_t vc_i,

  vc_alloc_if.port_side alloc,

  output flit_t [floo_pkg::NumVC-1:0] head_flit_o,
  output logic credit_v_o,
  output floo_pkg::vc_id_t credit_id_o
);
  import floo_pkg::*;

  flit_t mem_q [NumVC][VCDepth];
  logic [VCPtrWidth-1:0] wr_ptr_q [NumVC];
  logic [VCPtrWidth-1:0] rd_ptr_q [NumVC];
  logic [CreditWidth-1:0] count_q [NumVC];
  logic [NumVC-1:0] push;
  logic [NumVC-1:0] pop;

  always_comb begin
    for (int v = 0; v < NumVC; v++) begin
      push[v] = valid_i && (vc_i == vc_id_t'(v));
      pop[v] = alloc.grant_v && (alloc.grant_vc == vc_id_t'(v));
      head_flit_o[v] = mem_q[v][rd_ptr_q[v]];
      alloc.req_v[v] = (count_q[v] != '0);
      // Route is taken from the head header and the node position
      alloc.out_port[v] = xy_route(head_flit_o[v].hdr.dst, id_i);
    end
  end

  // Flit storage
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      mem_q[vc_i][wr_ptr_q[vc_i]] <= flit_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int v = 0; v < NumVC; v++) begin
        wr_ptr_q[v] <= '0;
        rd_ptr_q[v] <= '0;
        count_q[v] <= '0;
      end
      credit_v_o <= 1'b0;
    end else begin
      for (int v = 0; v < NumVC; v++) begin
        if (push[v]) begin
          wr_ptr_q[v] <= (wr_ptr_q[v] == VCPtrWidth'(VCDepth - 1)) ? '0 : wr_ptr_q[v] + 1'b1;
        end
        if (pop[v]) begin
          rd_ptr_q[v] <= (rd_ptr_q[v] == VCPtrWidth'(VCDepth - 1)) ? '0 : rd_ptr_q[v] + 1'b1;
        end
        if (push[v] && !pop[v]) begin
          count_q[v] <= count_q[v] + 1'b1;
        end else if (pop[v] && !push[v]) begin
          count_q[v] <= count_q[v] - 1'b1;
        end
      end
      // Freed slot is returned upstream as a credit
      credit_v_o <= alloc.grant_v;
    end
  end

  always_ff @(posedge clk_i) begin
    credit_id_o <= alloc.grant_vc;
  end

  // Upstream must hold a credit for every flit it sends
  assert property (@(posedge clk_i) disable iff (reset_i)
    valid_i |-> (count_q[vc_i] != CreditWidth'(VCDepth)));

endmodule

// ==== logic/vc_switch_alloc.sv ====
`timescale 1ns/100ps

module vc_switch_alloc (
  input  logic clk_i,
  input  logic reset_i,

  vc_alloc_if.alloc_side alloc [floo_pkg::NumPorts],

  input  logic [floo_pkg::NumPorts-1:0] out_credit_v_i,
  input  floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] out_credit_id_i,

  output floo_pkg::port_e [floo_pkg::NumPorts-1:0] sel_port_o,
  output floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] sel_vc_o,
  output logic [floo_pkg::NumPorts-1:0] out_v_o
);
  import floo_pkg::*;

  logic [NumVC-1:0] req_v [NumPorts];
  port_e out_port [NumPorts][NumVC];
  logic [NumPorts-1:0] grant_v;
  vc_id_t grant_vc [NumPorts];

  logic [CreditWidth-1:0] credit_q [NumPorts][NumVC];
  logic [CreditWidth-1:0] credit_d [NumPorts][NumVC];
  logic [ReqIdWidth-1:0] rr_q [NumPorts];
  logic [ReqIdWidth-1:0] rr_d [NumPorts];
  logic [PortIdWidth-1:0] rot_q;
  logic [NumPorts-1:0] gnt_mask [NumPorts];

  // Interface arrays need constant indices
  for (genvar i = 0; i < NumPorts; i++) begin : gen_bus
    assign req_v[i] = alloc[i].req_v;
    assign out_port[i] = alloc[i].out_port;
    assign alloc[i].grant_v = grant_v[i];
    assign alloc[i].grant_vc = grant_vc[i];
  end

  // Outputs are served in a rotating order so no input is favored when
  // two of its VCs compete for different outputs
  always_comb begin : alloc_comb
    int o;
    int r;
    int ip;
    int v;
    logic [NumPorts-1:0] in_taken;
    logic found;
    in_taken = '0;
    grant_v = '0;
    out_v_o = '0;
    for (int p = 0; p < NumPorts; p++) begin
      grant_vc[p] = '0;
      sel_port_o[p] = PortN;
      sel_vc_o[p] = '0;
      rr_d[p] = rr_q[p];
    end
    for (int k = 0; k < NumPorts; k++) begin
      o = (int'(rot_q) + k) % NumPorts;
      found = 1'b0;
      for (int j = 0; j < NumReq; j++) begin
        r = (int'(rr_q[o]) + j) % NumReq;
        ip = r / NumVC;
        v = r % NumVC;
        if (!found && !in_taken[ip] && req_v[ip][v] &&
            out_port[ip][v] == port_e'(o) && credit_q[o][v] != '0) begin
          found = 1'b1;
          in_taken[ip] = 1'b1;
          grant_v[ip] = 1'b1;
          grant_vc[ip] = vc_id_t'(v);
          out_v_o[o] = 1'b1;
          sel_port_o[o] = port_e'(ip);
          sel_vc_o[o] = vc_id_t'(v);
          rr_d[o] = ReqIdWidth'((r + 1) % NumReq);
        end
      end
    end
  end

  // Inputs granted towards each output, seen from the input side
  always_comb begin
    for (int o = 0; o < NumPorts; o++) begin
      for (int i = 0; i < NumPorts; i++) begin
        gnt_mask[o][i] = grant_v[i] && (out_port[i][grant_vc[i]] == port_e'(o));
      end
    end
  end

  // Credits leave with each grant and come back from downstream
  always_comb begin
    for (int o = 0; o < NumPorts; o++) begin
      for (int v = 0; v < NumVC; v++) begin
        credit_d[o][v] = credit_q[o][v];
        if (out_v_o[o] && sel_vc_o[o] == vc_id_t'(v)) begin
          credit_d[o][v] = credit_d[o][v] - 1'b1;
        end
        if (out_credit_v_i[o] && out_credit_id_i[o] == vc_id_t'(v)) begin
          credit_d[o][v] = credit_d[o][v] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int o = 0; o < NumPorts; o++) begin
        for (int v = 0; v < NumVC; v++) begin
          credit_q[o][v] <= CreditWidth'(VCDepth);
        end
        rr_q[o] <= '0;
      end
      rot_q <= '0;
    end else begin
      credit_q <= credit_d;
      rr_q <= rr_d;
      rot_q <= (rot_q == PortIdWidth'(NumPorts - 1)) ? '0 : rot_q + 1'b1;
    end
  end

  for (genvar o = 0; o < NumPorts; o++) begin : gen_checks
    assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(gnt_mask[o]));
    for (genvar v = 0; v < NumVC; v++) begin : gen_vc
      // Downstream never returns more credits than it was given
      assert property (@(posedge clk_i) disable iff (reset_i)
        credit_q[o][v] <= CreditWidth'(VCDepth));
    end
  end

endmodule

// ==== logic/vc_router.sv ====
`timescale 1ns/100ps

module vc_router #(
  parameter type flit_t = floo_pkg::req_flit_t
) (
  input  logic clk_i,
  input  logic reset_i,
  input  floo_pkg::coord_t id_i,

  input  logic [floo_pkg::NumPorts-1:0] data_v_i,
  input  flit_t [floo_pkg::NumPorts-1:0] data_i,
  input  floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] data_vc_i,
  input  logic [floo_pkg::NumPorts-1:0] credit_v_i,
  input  floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] credit_id_i,

  output logic [floo_pkg::NumPorts-1:0] data_v_o,
  output flit_t [floo_pkg::NumPorts-1:0] data_o,
  output floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] data_vc_o,
  output logic [floo_pkg::NumPorts-1:0] credit_v_o,
  output floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] credit_id_o
);
  import floo_pkg::*;

  vc_alloc_if alloc_bus [NumPorts] ();

  flit_t [NumVC-1:0] head_flit [NumPorts];
  port_e [NumPorts-1:0] sel_port;
  vc_id_t [NumPorts-1:0] sel_vc;
  logic [NumPorts-1:0] out_v;
  flit_t [NumPorts-1:0] xbar_flit;

  for (genvar i = 0; i < NumPorts; i++) begin : gen_in
    vc_input_port #(
      .flit_t      (flit_t)
    ) i_input_port (
      .clk_i,
      .reset_i,
      .id_i,
      .valid_i     (data_v_i[i]),
      .flit_i      (data_i[i]),
      .vc_i        (data_vc_i[i]),
      .alloc       (alloc_bus[i]),
      .head_flit_o (head_flit[i]),
      .credit_v_o  (credit_v_o[i]),
      .credit_id_o (credit_id_o[i])
    );
  end

  vc_switch_alloc i_switch_alloc (
    .clk_i,
    .reset_i,
    .alloc           (alloc_bus),
    .out_credit_v_i  (credit_v_i),
    .out_credit_id_i (credit_id_i),
    .sel_port_o      (sel_port),
    .sel_vc_o        (sel_vc),
    .out_v_o         (out_v)
  );

  // Crossbar
  always_comb begin
    for (int o = 0; o < NumPorts; o++) begin
      xbar_flit[o] = head_flit[sel_port[o]][sel_vc[o]];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) data_v_o <= '0;
    else data_v_o <= out_v;
  end

  // VC is kept from input to output
  always_ff @(posedge clk_i) begin
    for (int o = 0; o < NumPorts; o++) begin
      if (out_v[o]) begin
        data_o[o] <= xbar_flit[o];
        data_vc_o[o] <= sel_vc[o];
      end
    end
  end

endmodule

// ==== logic/floo_narrow_wide_router.sv ====
`timescale 1ns/100ps

// Three independent networks through one node
module floo_narrow_wide_router (
  input  logic clk_i,
  input  logic reset_i,
  input  floo_pkg::coord_t id_i,

  input  logic [floo_pkg::NumPorts-1:0] req_v_i,
  input  floo_pkg::req_flit_t [floo_pkg::NumPorts-1:0] req_flit_i,
  input  floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] req_vc_i,
  input  logic [floo_pkg::NumPorts-1:0] req_credit_v_i,
  input  floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] req_credit_id_i,
  output logic [floo_pkg::NumPorts-1:0] req_v_o,
  output floo_pkg::req_flit_t [floo_pkg::NumPorts-1:0] req_flit_o,
  output floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] req_vc_o,
  output logic [floo_pkg::NumPorts-1:0] req_credit_v_o,
  output floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] req_credit_id_o,

  input  logic [floo_pkg::NumPorts-1:0] rsp_v_i,
  input  floo_pkg::rsp_flit_t [floo_pkg::NumPorts-1:0] rsp_flit_i,
  input  floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] rsp_vc_i,
  input  logic [floo_pkg::NumPorts-1:0] rsp_credit_v_i,
  input  floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] rsp_credit_id_i,
  output logic [floo_pkg::NumPorts-1:0] rsp_v_o,
  output floo_pkg::rsp_flit_t [floo_pkg::NumPorts-1:0] rsp_flit_o,
  output floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] rsp_vc_o,
  output logic [floo_pkg::NumPorts-1:0] rsp_credit_v_o,
  output floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] rsp_credit_id_o,

  input  logic [floo_pkg::NumPorts-1:0] wide_v_i,
  input  floo_pkg::wide_flit_t [floo_pkg::NumPorts-1:0] wide_flit_i,
  input  floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] wide_vc_i,
  input  logic [floo_pkg::NumPorts-1:0] wide_credit_v_i,
  input  floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] wide_credit_id_i,
  output logic [floo_pkg::NumPorts-1:0] wide_v_o,
  output floo_pkg::wide_flit_t [floo_pkg::NumPorts-1:0] wide_flit_o,
  output floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] wide_vc_o,
  output logic [floo_pkg::NumPorts-1:0] wide_credit_v_o,
  output floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] wide_credit_id_o
);
  import floo_pkg::*;

  vc_router #(.flit_t(req_flit_t)) i_req_router (
    .clk_i,
    .reset_i,
    .id_i,
    .data_v_i    (req_v_i),
    .data_i      (req_flit_i),
    .data_vc_i   (req_vc_i),
    .credit_v_i  (req_credit_v_i),
    .credit_id_i (req_credit_id_i),
    .data_v_o    (req_v_o),
    .data_o      (req_flit_o),
    .data_vc_o   (req_vc_o),
    .credit_v_o  (req_credit_v_o),
    .credit_id_o (req_credit_id_o)
  );

  vc_router #(.flit_t(rsp_flit_t)) i_rsp_router (
    .clk_i,
    .reset_i,
    .id_i,
    .data_v_i    (rsp_v_i),
    .data_i      (rsp_flit_i),
    .data_vc_i   (rsp_vc_i),
    .credit_v_i  (rsp_credit_v_i),
    .credit_id_i (rsp_credit_id_i),
    .data_v_o    (rsp_v_o),
    .data_o      (rsp_flit_o),
    .data_vc_o   (rsp_vc_o),
    .credit_v_o  (rsp_credit_v_o),
    .credit_id_o (rsp_credit_id_o)
  );

  // Wide data network
  vc_router #(.flit_t(wide_flit_t)) i_wide_router (
    .clk_i,
    .reset_i,
    .id_i,
    .data_v_i    (wide_v_i),
    .data_i      (wide_flit_i),
    .data_vc_i   (wide_vc_i),
    .credit_v_i  (wide_credit_v_i),
    .credit_id_i (wide_credit_id_i),
    .data_v_o    (wide_v_o),
    .data_o      (wide_flit_o),
    .data_vc_o   (wide_vc_o),
    .credit_v_o  (wide_credit_v_o),
    .credit_id_o (wide_credit_id_o)
  );

endmodule

// ==== verification/floo_router_checker.sv ====
`timescale 1ns/100ps

`include "floo_dirs.svh"

module floo_router_checker (
  input logic clk_i,
  input logic reset_i,
  input floo_pkg::coord_t id_i,

  input logic [floo_pkg::NumPorts-1:0] req_v_i,
  input floo_pkg::req_flit_t [floo_pkg::NumPorts-1:0] req_flit_i,
  input floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] req_vc_i,
  input logic [floo_pkg::NumPorts-1:0] req_credit_v_i,
  input floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] req_credit_id_i,
  input logic [floo_pkg::NumPorts-1:0] req_v_o,
  input floo_pkg::req_flit_t [floo_pkg::NumPorts-1:0] req_flit_o,
  input floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] req_vc_o,
  input logic [floo_pkg::NumPorts-1:0] req_credit_v_o,
  input floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] req_credit_id_o,

  input logic [floo_pkg::NumPorts-1:0] rsp_v_i,
  input floo_pkg::rsp_flit_t [floo_pkg::NumPorts-1:0] rsp_flit_i,
  input floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] rsp_vc_i,
  input logic [floo_pkg::NumPorts-1:0] rsp_credit_v_i,
  input floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] rsp_credit_id_i,
  input logic [floo_pkg::NumPorts-1:0] rsp_v_o,
  input floo_pkg::rsp_flit_t [floo_pkg::NumPorts-1:0] rsp_flit_o,
  input floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] rsp_vc_o,
  input logic [floo_pkg::NumPorts-1:0] rsp_credit_v_o,
  input floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] rsp_credit_id_o,

  input logic [floo_pkg::NumPorts-1:0] wide_v_i,
  input floo_pkg::wide_flit_t [floo_pkg::NumPorts-1:0] wide_flit_i,
  input floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] wide_vc_i,
  input logic [floo_pkg::NumPorts-1:0] wide_credit_v_i,
  input floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] wide_credit_id_i,
  input logic [floo_pkg::NumPorts-1:0] wide_v_o,
  input floo_pkg::wide_flit_t [floo_pkg::NumPorts-1:0] wide_flit_o,
  input floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] wide_vc_o,
  input logic [floo_pkg::NumPorts-1:0] wide_credit_v_o,
  input floo_pkg::vc_id_t [floo_pkg::NumPorts-1:0] wide_credit_id_o
);
  import floo_pkg::*;

  typedef struct packed {
    logic [2:0] in_port;
    logic [31:0] cycle;
    hdr_t hdr;
    logic [63:0] payload;
  } entry_t;

  // Expected flits per network, output port and VC
  entry_t exp_q [30][$];
  int outstanding [15][2];
  int ds_credit [15][2];
  int cycle = 0;
  int since_reset = 0;
  int errors = 0;
  int checked = 0;
  bit first_seen = 1'b0;

  initial begin
    for (int i = 0; i < 15; i++) begin
      for (int v = 0; v < 2; v++) begin
        outstanding[i][v] = 0;
        ds_credit[i][v] = VCDepth;
      end
    end
  end

  function automatic string net_name(int n);
    return (n == 0) ? "req" : (n == 1) ? "rsp" : "wide";
  endfunction

  // Dimension ordered, X before Y, east is +x and north is +y
  function automatic int ref_port(coord_t dst, coord_t here);
    if (dst.x > here.x) return `FLOO_DIR_E;
    if (dst.x < here.x) return `FLOO_DIR_W;
    if (dst.y > here.y) return `FLOO_DIR_N;
    if (dst.y < here.y) return `FLOO_DIR_S;
    return `FLOO_DIR_L;
  endfunction

  function automatic int pending_count();
    int sum;
    sum = 0;
    for (int i = 0; i < 30; i++) sum += exp_q[i].size();
    return sum;
  endfunction

  task automatic note_in(int n, int p, logic v, vc_id_t vc, hdr_t h, logic [63:0] pay);
    entry_t e;
    int qi;
    if (!v) return;
    e.in_port = 3'(p);
    e.cycle = 32'(cycle);
    e.hdr = h;
    e.payload = pay;
    qi = n * 10 + ref_port(h.dst, id_i) * 2 + int'(vc);
    exp_q[qi].push_back(e);
    outstanding[n * 5 + p][vc]++;
    if (outstanding[n * 5 + p][vc] > VCDepth) begin
      errors++;
      $display("ERROR: %s input %0d VC %0d sent a flit without a credit", net_name(n), p, vc);
    end
  endtask

  task automatic note_credit(int n, int p, logic cv, vc_id_t cid);
    if (!cv) return;
    outstanding[n * 5 + p][cid]--;
    if (outstanding[n * 5 + p][cid] < 0) begin
      errors++;
      $display("ERROR: %s input %0d VC %0d returned a credit for no flit", net_name(n), p, cid);
    end
  endtask

  task automatic note_ds_credit(int n, int o, logic cv, vc_id_t cid);
    if (!cv) return;
    ds_credit[n * 5 + o][cid]++;
  endtask

  task automatic note_out(int n, int o, logic v, vc_id_t vc, hdr_t h, logic [63:0] pay);
    int qi;
    int idx;
    int lat;
    entry_t e;
    if (!v) return;
    checked++;
    if (ref_port(h.dst, id_i) != o) begin
      errors++;
      $display("MISMATCH test=routing net=%s expected=%0d actual=%0d",
               net_name(n), ref_port(h.dst, id_i), o);
    end
    ds_credit[n * 5 + o][vc]--;
    if (ds_credit[n * 5 + o][vc] < 0) begin
      errors++;
      $display("ERROR: %s output %0d VC %0d sent a flit while credits were held",
               net_name(n), o, vc);
    end
    qi = n * 10 + o * 2 + int'(vc);
    idx = -1;
    for (int k = 0; k < exp_q[qi].size(); k++) begin
      if (idx < 0 && exp_q[qi][k].hdr.src == h.src && exp_q[qi][k].hdr.seq == h.seq) idx = k;
    end
    if (idx < 0) begin
      errors++;
      $display("ERROR: %s output %0d VC %0d carried tag %0d that was never sent there",
               net_name(n), o, vc, h.seq);
      return;
    end
    e = exp_q[qi][idx];
    if ({e.hdr, e.payload} != {h, pay}) begin
      errors++;
      $display("MISMATCH test=integrity net=%s expected=%h actual=%h",
               net_name(n), {e.hdr, e.payload}, {h, pay});
    end
    for (int k = 0; k < idx; k++) begin
      if (exp_q[qi][k].in_port == e.in_port) begin
        errors++;
        $display("ERROR: %s flit tag %0d overtook an older flit of input %0d",
                 net_name(n), h.seq, e.in_port);
      end
    end
    lat = cycle - int'(e.cycle);
    if (!first_seen) begin
      first_seen = 1'b1;
      if (lat != 2) begin
        errors++;
        $display("MISMATCH test=latency net=%s expected=2 actual=%0d", net_name(n), lat);
      end
    end else if (lat < 2) begin
      errors++;
      $display("MISMATCH test=min_latency net=%s expected=2 actual=%0d", net_name(n), lat);
    end
    exp_q[qi].delete(idx);
  endtask

  always @(posedge clk_i) begin
    cycle++;
    since_reset = reset_i ? 0 : since_reset + 1;
    if ((reset_i && cycle >= 2) || (!reset_i && since_reset <= 3)) begin
      if ((req_v_o | rsp_v_o | wide_v_o | req_credit_v_o | rsp_credit_v_o |
           wide_credit_v_o) != '0) begin
        errors++;
        $display("ERROR: valid or credit output high around reset in cycle %0d", cycle);
      end
    end
    if (!reset_i) begin
      for (int p = 0; p < NumPorts; p++) begin
        note_in(0, p, req_v_i[p], req_vc_i[p], req_flit_i[p].hdr, {32'b0, req_flit_i[p].payload});
        note_in(1, p, rsp_v_i[p], rsp_vc_i[p], rsp_flit_i[p].hdr, {32'b0, rsp_flit_i[p].payload});
        note_in(2, p, wide_v_i[p], wide_vc_i[p], wide_flit_i[p].hdr, wide_flit_i[p].payload);
        note_credit(0, p, req_credit_v_o[p], req_credit_id_o[p]);
        note_credit(1, p, rsp_credit_v_o[p], rsp_credit_id_o[p]);
        note_credit(2, p, wide_credit_v_o[p], wide_credit_id_o[p]);
        note_out(0, p, req_v_o[p], req_vc_o[p], req_flit_o[p].hdr, {32'b0, req_flit_o[p].payload});
        note_out(1, p, rsp_v_o[p], rsp_vc_o[p], rsp_flit_o[p].hdr, {32'b0, rsp_flit_o[p].payload});
        note_out(2, p, wide_v_o[p], wide_vc_o[p], wide_flit_o[p].hdr, wide_flit_o[p].payload);
        note_ds_credit(0, p, req_credit_v_i[p], req_credit_id_i[p]);
        note_ds_credit(1, p, rsp_credit_v_i[p], rsp_credit_id_i[p]);
        note_ds_credit(2, p, wide_credit_v_i[p], wide_credit_id_i[p]);
      end
    end
  end

  // End of run balance of all credit loops and queues
  task automatic report();
    for (int i = 0; i < 15; i++) begin
      for (int v = 0; v < 2; v++) begin
        if (outstanding[i][v] != 0) begin
          errors++;
          $display("ERROR: %s input %0d VC %0d returned fewer credits than flits accepted",
                   net_name(i / 5), i % 5, v);
        end
        if (ds_credit[i][v] != VCDepth) begin
          errors++;
          $display("ERROR: %s output %0d VC %0d did not get all credits back",
                   net_name(i / 5), i % 5, v);
        end
      end
    end
    if (pending_count() != 0) begin
      errors++;
      $display("ERROR: %0d flits never left the router", pending_count());
    end
    $display("Checked %0d flits, %0d errors", checked, errors);
  endtask

endmodule

// ==== verification/tb_floo_router.sv ====
`timescale 1ns/100ps

`include "floo_dirs.svh"

module tb_floo_router;
  import floo_pkg::*;

  localparam int FlitsPerNet = 150;
  localparam int TimeoutCycles = (3 * FlitsPerNet + 1) * 20 + 2000;

  logic clk_i = 1'b0;
  logic reset_i = 1'b1;
  coord_t id_i = '{x: 2'd1, y: 2'd1};

  logic [NumPorts-1:0] req_v_i, req_credit_v_i, req_v_o, req_credit_v_o;
  req_flit_t [NumPorts-1:0] req_flit_i, req_flit_o;
  vc_id_t [NumPorts-1:0] req_vc_i, req_credit_id_i, req_vc_o, req_credit_id_o;
  logic [NumPorts-1:0] rsp_v_i, rsp_credit_v_i, rsp_v_o, rsp_credit_v_o;
  rsp_flit_t [NumPorts-1:0] rsp_flit_i, rsp_flit_o;
  vc_id_t [NumPorts-1:0] rsp_vc_i, rsp_credit_id_i, rsp_vc_o, rsp_credit_id_o;
  logic [NumPorts-1:0] wide_v_i, wide_credit_v_i, wide_v_o, wide_credit_v_o;
  wide_flit_t [NumPorts-1:0] wide_flit_i, wide_flit_o;
  vc_id_t [NumPorts-1:0] wide_vc_i, wide_credit_id_i, wide_vc_o, wide_credit_id_o;

  int seed = 32'h30a8;
  int cyc = 0;
  int up_cred [3][5][2];
  int sent [3];
  logic [7:0] tag [3];
  int due_q [15][$];
  bit vc_q [15][$];
  bit traffic_on = 1'b0;
  bit probe_pending = 1'b0;
  bit hold = 1'b0;

  floo_narrow_wide_router DUT (.*);

  floo_router_checker u_chk (.*);

  initial begin
    forever #20 clk_i = ~clk_i;
  end

  initial begin
    #(TimeoutCycles * 40);
    $display("TIMEOUT: traffic did not drain within %0d cycles", TimeoutCycles);
    $display("Regression failed");
    $finish;
  end

  task automatic send_flit(int n, int p, coord_t dst, vc_id_t vc, logic [63:0] pay);
    hdr_t h;
    h.dst = dst;
    h.src = coord_t'(4'(p));
    h.seq = tag[n];
    tag[n] = tag[n] + 8'd1;
    up_cred[n][p][vc]--;
    case (n)
      0: begin
        req_v_i[p] = 1'b1;
        req_flit_i[p] = '{hdr: h, payload: pay[31:0]};
      end
      1: begin
        rsp_v_i[p] = 1'b1;
        rsp_flit_i[p] = '{hdr: h, payload: pay[31:0]};
      end
      default: begin
        wide_v_i[p] = 1'b1;
        wide_flit_i[p] = '{hdr: h, payload: pay};
      end
    endcase
    case (n)
      0: req_vc_i[p] = vc;
      1: rsp_vc_i[p] = vc;
      default: wide_vc_i[p] = vc;
    endcase
  endtask

  task automatic schedule_credit(int n, int o, vc_id_t vc);
    logic [31:0] r;
    r = $random(seed);
    due_q[n * 5 + o].push_back(cyc + int'(r[7:0]) % 6);
    vc_q[n * 5 + o].push_back(vc);
  endtask

  task automatic return_credit(int n, int o, vc_id_t vc);
    case (n)
      0: begin
        req_credit_v_i[o] = 1'b1;
        req_credit_id_i[o] = vc;
      end
      1: begin
        rsp_credit_v_i[o] = 1'b1;
        rsp_credit_id_i[o] = vc;
      end
      default: begin
        wide_credit_v_i[o] = 1'b1;
        wide_credit_id_i[o] = vc;
      end
    endcase
  endtask

  function automatic bit downstream_idle();
    for (int q = 0; q < 15; q++) begin
      if (due_q[q].size() != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  // Upstream and downstream link models
  always @(posedge clk_i) begin
    logic [31:0] r;
    vc_id_t vc;
    if (!reset_i) begin
      cyc++;
      for (int p = 0; p < NumPorts; p++) begin
        if (req_credit_v_o[p]) up_cred[0][p][req_credit_id_o[p]]++;
        if (rsp_credit_v_o[p]) up_cred[1][p][rsp_credit_id_o[p]]++;
        if (wide_credit_v_o[p]) up_cred[2][p][wide_credit_id_o[p]]++;
        if (req_v_o[p]) schedule_credit(0, p, req_vc_o[p]);
        if (rsp_v_o[p]) schedule_credit(1, p, rsp_vc_o[p]);
        if (wide_v_o[p]) schedule_credit(2, p, wide_vc_o[p]);
      end
    end
    #2;
    req_v_i = '0;
    rsp_v_i = '0;
    wide_v_i = '0;
    req_credit_v_i = '0;
    rsp_credit_v_i = '0;
    wide_credit_v_i = '0;
    if (probe_pending) begin
      send_flit(0, `FLOO_DIR_L, '{x: 2'd1, y: 2'd1}, 1'b0, 64'h0000_0000_c0de_0001);
      probe_pending = 1'b0;
    end
    for (int n = 0; n < 3; n++) begin
      for (int p = 0; p < NumPorts; p++) begin
        r = $random(seed);
        vc = r[1];
        if (traffic_on && sent[n] < FlitsPerNet && r[0] && up_cred[n][p][vc] > 0) begin
          send_flit(n, p, coord_t'(r[7:4]), vc, {$random(seed), $random(seed)});
          sent[n]++;
        end
      end
    end
    for (int q = 0; q < 15; q++) begin
      if (!hold && due_q[q].size() != 0 && due_q[q][0] <= cyc) begin
        return_credit(q / 5, q % 5, vc_q[q][0]);
        void'(due_q[q].pop_front());
        void'(vc_q[q].pop_front());
      end
    end
  end

  initial begin
    for (int n = 0; n < 3; n++) begin
      sent[n] = 0;
      tag[n] = 8'd0;
      for (int p = 0; p < 5; p++) begin
        up_cred[n][p][0] = VCDepth;
        up_cred[n][p][1] = VCDepth;
      end
    end
    {req_v_i, req_flit_i, req_vc_i, req_credit_v_i, req_credit_id_i} = '0;
    {rsp_v_i, rsp_flit_i, rsp_vc_i, rsp_credit_v_i, rsp_credit_id_i} = '0;
    {wide_v_i, wide_flit_i, wide_vc_i, wide_credit_v_i, wide_credit_id_i} = '0;
    repeat (10) @(posedge clk_i);
    #2 reset_i = 1'b0;
    repeat (5) @(posedge clk_i);
    // Single flit on an idle router for the latency probe
    probe_pending = 1'b1;
    repeat (8) @(posedge clk_i);
    traffic_on = 1'b1;
    repeat (20) @(posedge clk_i);
    hold = 1'b1;
    repeat (60) @(posedge clk_i);
    hold = 1'b0;
    while (sent[0] < FlitsPerNet || sent[1] < FlitsPerNet || sent[2] < FlitsPerNet)
      @(posedge clk_i);
    while (u_chk.pending_count() != 0 || !downstream_idle()) @(posedge clk_i);
    repeat (10) @(posedge clk_i);
    u_chk.report();
    if (u_chk.errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+include
logic/floo_pkg.sv
logic/vc_alloc_if.sv
logic/vc_input_port.sv
logic/vc_switch_alloc.sv
logic/vc_router.sv
logic/floo_narrow_wide_router.sv
verification/floo_router_checker.sv
verification/tb_floo_router.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_floo_router -o sim_tb

output=$(./obj_dir/sim_tb)
echo "$output"

if echo "$output" | grep -q "^Regression passed$"; then
  exit 0
fi
exit 1
